// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the wire link testbench with Verilator and run it.
# The exit status is 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

build_dir="obj_dir"
sim_bin="wire_link_sim"
log_file="sim.log"

verilator --binary --timing --assert -Wno-fatal \
  -f wire_link_top.f \
  --top-module wire_link_tb \
  -Mdir "${build_dir}" \
  -o "${sim_bin}"
build_status=$?
if [ ${build_status} -ne 0 ]; then
  echo "Verilator build failed with status ${build_status}"
  exit 1
fi

"./${build_dir}/${sim_bin}" > "${log_file}" 2>&1
run_status=$?
cat "${log_file}"
if [ ${run_status} -ne 0 ]; then
  echo "Simulation exited with status ${run_status}"
  exit 1
fi

if grep -qx 'All tests passed!' "${log_file}"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

// ==== verification/wire_link_tb.sv ====
// wire link testbench with clock, reset, producer and consumer models, scoreboard and assertions

`timescale 1ns/100ps

module wire_link_tb
  import wire_link_pkg::*;
();

  // cycles from in_ack rising to out_req rising on an idle link
  localparam int latency      = fwd_stages + 3;
  localparam int wait_limit   = 500;
  localparam int single_words = 20;
  localparam int stream_words = 300;
  localparam int stall_words  = buf_depth + 4;
  localparam int unsigned rand_seed = 32'h2eb2_6b3f;

  logic              clk     = 1'b0;
  logic              reset   = 1'b1;
  logic              in_req  = 1'b0;
  logic [data_w-1:0] in_data = '0;
  logic              out_ack = 1'b0;
  logic              in_ack;
  logic              out_req;
  logic [data_w-1:0] out_data;

  // ------------------------------
  // scoreboard and monitor state
  // ------------------------------

  // words accepted at in_ack and not yet handed to the consumer, oldest first
  logic [data_w-1:0] scoreboard [$];
  logic [data_w-1:0] exp_head;
  logic [data_w-1:0] out_data_q;
  logic              head_valid;
  logic              in_ack_q;
  logic              in_req_q;
  logic              out_req_q;
  logic              seen_req;
  logic              in_ack_rise;
  logic              handoff;
  // a word launched into a completely idle link, which fixes its latency
  logic              launch_idle;
  // set while the consumer withholds out_ack on purpose
  logic              stalling = 1'b0;
  int                in_flight;
  int                stall_rises;
  int                words_in;
  int                words_out;
  int                latency_launches;
  int                assert_errors = 0;
  int                check_errors  = 0;

  always #20 clk = ~clk;

  wire_link_top i_dut (
    .clk      (clk),
    .reset    (reset),
    .in_req   (in_req),
    .in_data  (in_data),
    .in_ack   (in_ack),
    .out_ack  (out_ack),
    .out_req  (out_req),
    .out_data (out_data)
  );

  assign in_ack_rise = in_ack && !in_ack_q;
  assign handoff     = out_req && out_ack;
  assign launch_idle = in_ack_rise && (in_flight == 0) && !out_req && !out_ack;

  // values read here are the ones from just before the edge
  always @(posedge clk) begin
    if (reset) begin
      scoreboard.delete();
      {in_ack_q, in_req_q, out_req_q, seen_req, head_valid} <= '0;
      exp_head         <= '0;
      out_data_q       <= '0;
      in_flight        <= 0;
      stall_rises      <= 0;
      words_in         <= 0;
      words_out        <= 0;
      latency_launches <= 0;
    end else begin
      in_ack_q   <= in_ack;
      in_req_q   <= in_req;
      out_req_q  <= out_req;
      out_data_q <= out_data;
      if (in_req) seen_req <= 1'b1;
      if (launch_idle) latency_launches <= latency_launches + 1;
      // the consumer took the head word, so retire it before any new word joins
      if (handoff && scoreboard.size() > 0) void'(scoreboard.pop_front());
      if (in_ack_rise) scoreboard.push_back(in_data);
      if (in_ack_rise && stalling) stall_rises <= stall_rises + 1;
      words_in   <= words_in + (in_ack_rise ? 1 : 0);
      words_out  <= words_out + (handoff ? 1 : 0);
      in_flight  <= in_flight + (in_ack_rise ? 1 : 0) - (handoff ? 1 : 0);
      head_valid <= (scoreboard.size() > 0);
      if (scoreboard.size() > 0) exp_head <= scoreboard[0];
    end
  end

  // ------------------------------
  // checks
  // ------------------------------

  a_reset_idle: assert property (@(posedge clk) disable iff (reset)
    !seen_req |-> !in_ack && !out_req)
    else begin
      assert_errors++;
      $display("** Error [reset_idle] expected in_ack=0 out_req=0 actual in_ack=%b out_req=%b",
               $sampled(in_ack), $sampled(out_req));
    end

  a_order: assert property (@(posedge clk) disable iff (reset)
    out_req |-> head_valid && out_data == exp_head)
    else begin
      assert_errors++;
      if (!$sampled(head_valid)) begin
        $display("out_req is high but no accepted word is outstanding");
      end else begin
        $display("** Error [order] expected %h actual %h",
                 $sampled(exp_head), $sampled(out_data));
      end
    end

  a_latency: assert property (@(posedge clk) disable iff (reset)
    $past(launch_idle, latency) |-> out_req && !out_req_q)
    else begin
      assert_errors++;
      $display("** Error [latency] expected out_req rising %0d cycles after in_ack, actual %b->%b",
               latency, $sampled(out_req_q), $sampled(out_req));
    end

  // the sender may never have more words out than the receiver has slots
  a_in_flight: assert property (@(posedge clk) disable iff (reset) in_flight <= buf_depth)
    else begin
      assert_errors++;
      $display("** Error [in_flight] expected at most %0d actual %0d",
               buf_depth, $sampled(in_flight));
    end

  a_stall: assert property (@(posedge clk) disable iff (reset) stall_rises <= buf_depth)
    else begin
      assert_errors++;
      $display("** Error [backpressure] expected at most %0d actual %0d",
               buf_depth, $sampled(stall_rises));
    end

  a_out_stable: assert property (@(posedge clk) disable iff (reset)
    out_req && out_req_q |-> out_data == out_data_q)
    else begin
      assert_errors++;
      $display("** Error [out_stable] expected %h actual %h",
               $sampled(out_data_q), $sampled(out_data));
    end

  a_ack_rule: assert property (@(posedge clk) disable iff (reset) in_ack_rise |-> in_req_q)
    else begin
      assert_errors++;
      $display("in_ack rose while in_req was low");
    end

  // ------------------------------
  // producer and consumer models
  // ------------------------------

  task automatic report_and_finish();
    $display("words sent %0d, words received %0d, assertion errors %0d, check errors %0d",
             words_in, words_out, assert_errors, check_errors);
    if (assert_errors == 0 && check_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    check_errors++;
    $display("timed out while waiting for %s", what);
    report_and_finish();
  endtask

  task automatic wait_in_ack(input logic level);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (in_ack !== level && cycles < wait_limit);
    if (in_ack !== level) abort_on_timeout($sformatf("in_ack to become %b", level));
  endtask

  task automatic wait_out_req(input logic level);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (out_req !== level && cycles < wait_limit);
    if (out_req !== level) abort_on_timeout($sformatf("out_req to become %b", level));
  endtask

  // in_data only changes on the edge that raises in_req, never while it is high
  task automatic send_word(input logic [data_w-1:0] word);
    @(posedge clk);
    in_req  <= 1'b1;
    in_data <= word;
    wait_in_ack(1'b1);
    in_req <= 1'b0;
    wait_in_ack(1'b0);
  endtask

  task automatic send_words(input int count, input int max_gap);
    for (int i = 0; i < count; i++) begin
      repeat ($urandom_range(max_gap, 0)) @(posedge clk);
      send_word($urandom);
    end
  endtask

  task automatic take_word(input int max_delay);
    int delay;
    wait_out_req(1'b1);
    delay = $urandom_range(max_delay, 0);
    repeat (delay) @(posedge clk);
    out_ack <= 1'b1;
    wait_out_req(1'b0);
    out_ack <= 1'b0;
  endtask

  task automatic take_words(input int count, input int max_delay);
    for (int i = 0; i < count; i++) begin
      take_word(max_delay);
    end
  endtask

  task automatic wait_stall_full();
    int cycles;
    cycles = 0;
    while (stall_rises < buf_depth && cycles < wait_limit) begin
      @(posedge clk);
      cycles++;
    end
    if (stall_rises < buf_depth) abort_on_timeout("the receiver buffer to fill during the stall");
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------

  initial begin
    void'($urandom(rand_seed));
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    // nothing may move on an idle link before the first request
    repeat (8) @(posedge clk);

    // isolated words into an empty buffer, each one timed by a_latency
    for (int i = 0; i < single_words; i++) begin
      fork
        send_word($urandom);
        take_word(4);
      join
    end

    // long stream with random producer gaps and random consumer delays
    fork
      send_words(stream_words, 3);
      take_words(stream_words, 6);
    join

    // consumer stalls, the sender runs out of credits and must wait
    @(posedge clk);
    stalling <= 1'b1;
    fork
      send_words(stall_words, 0);
      begin
        wait_stall_full();
        // give the sender time to misbehave if it ignores its credit count
        repeat (30) @(posedge clk);
        if (stall_rises != buf_depth) begin
          check_errors++;
          $display("** Error [backpressure] expected %0d actual %0d", buf_depth, stall_rises);
        end
        stalling <= 1'b0;
        take_words(stall_words, 2);
      end
    join

    repeat (latency + 4) @(posedge clk);
    if (scoreboard.size() != 0) begin
      check_errors++;
      $display("%0d accepted words never reached the consumer", scoreboard.size());
    end
    if (words_in != single_words + stream_words + stall_words) begin
      check_errors++;
      $display("** Error [count] expected %0d actual %0d",
               single_words + stream_words + stall_words, words_in);
    end
    if (words_out != words_in) begin
      check_errors++;
      $display("** Error [delivered] expected %0d actual %0d", words_in, words_out);
    end
    if (latency_launches == 0) begin
      check_errors++;
      $display("no word was ever launched into an idle link, latency went unchecked");
    end
    report_and_finish();
  end

endmodule : wire_link_tb

// ==== verilog/delay_valid_next.sv ====
// valid-next delay line with reset valid-next chain and enable-gated unreset data stages

`timescale 1ns/100ps

module delay_valid_next #(
  // bit width of the data path, at least 1
  parameter int Width = 1,
  // number of register stages, 0 gives a pure pass-through
  parameter int NumStages = 0
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             in_valid_next,
  input  logic [Width-1:0] in,
  output logic             out_valid_next,
  output logic [Width-1:0] out
);

  // ------------------------------
  // stage storage
  // ------------------------------

  // entry 0 is the input itself, entry NumStages is the output
  logic             stage_valid_next [0:NumStages];
  logic [Width-1:0] stage            [0:NumStages];

  assign stage_valid_next[0] = in_valid_next;
  assign stage[0]            = in;

  // ------------------------------
  // pipeline
  // ------------------------------

  for (genvar i = 1; i <= NumStages; i++) begin : gen_stage

    // the valid-next chain is cleared so nothing looks valid after reset
    always_ff @(posedge clk) begin
      if (reset) begin
        stage_valid_next[i] <= 1'b0;
      end else begin
        stage_valid_next[i] <= stage_valid_next[i-1];
      end
    end

    // stage_valid_next[i] acts as the valid for stage[i-1], so it is the
    // load enable here and the data stays one cycle behind its valid-next bit
    // no reset on the wide registers, they only move when a word passes
    always_ff @(posedge clk) begin
      if (stage_valid_next[i]) begin
        stage[i] <= stage[i-1];
      end
    end

  end

  // last stage drives the far end of the wire
  assign out_valid_next = stage_valid_next[NumStages];
  assign out            = stage[NumStages];

endmodule : delay_valid_next

// ==== verilog/link_receiver.sv ====
// link receiver with data capture, circular word buffer, output four-phase handshake and credit return

`timescale 1ns/100ps

module link_receiver
  import wire_link_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              dly_valid_next,
  input  logic [data_w-1:0] dly_data,
  input  logic              out_ack,
  output logic              out_req,
  output logic [data_w-1:0] out_data,
  output logic              credit_return
);

  // ------------------------------
  // declarations
  // ------------------------------

  // dly_valid_next moved one cycle later so it lines up with dly_data
  logic               data_valid;
  // word storage, one slot per credit the sender holds
  logic [data_w-1:0]  mem [buf_depth];
  // pointers carry one extra wrap bit to tell full from empty
  logic [buf_idx_w:0] wr_ptr;
  logic [buf_idx_w:0] rd_ptr;
  logic               buf_empty;
  // consumer has acknowledged the word at the head
  logic               handoff;
  // out_req one cycle back, for spotting its falling edge
  logic               out_req_q;

  // ------------------------------
  // capture
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      data_valid <= 1'b0;
    end else begin
      data_valid <= dly_valid_next;
    end
  end

  // the sender never launches without a credit, so a write
  // always finds a free slot
  always_ff @(posedge clk) begin
    if (data_valid) begin
      mem[wr_ptr[buf_idx_w-1:0]] <= dly_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (data_valid) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  assign buf_empty = (wr_ptr == rd_ptr);

  // ------------------------------
  // output handshake
  // ------------------------------

  assign handoff = out_req && out_ack;

  // head of the buffer; the slot is not rewritten while it is occupied,
  // so this stays stable for the whole time out_req is high
  assign out_data = mem[rd_ptr[buf_idx_w-1:0]];

  always_ff @(posedge clk) begin
    if (reset) begin
      out_req <= 1'b0;
    end else if (!out_req && !out_ack && !buf_empty) begin
      // previous handshake is fully closed and a word is waiting
      out_req <= 1'b1;
    end else if (handoff) begin
      out_req <= 1'b0;
    end
  end

  // the slot is released on the same edge that drops out_req
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (handoff) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // ------------------------------
  // credit return
  // ------------------------------

  // one pulse per freed slot, issued the edge after out_req falls
  always_ff @(posedge clk) begin
    if (reset) begin
      out_req_q     <= 1'b0;
      credit_return <= 1'b0;
    end else begin
      out_req_q     <= out_req;
      credit_return <= out_req_q && !out_req;
    end
  end

endmodule : link_receiver

// ==== verilog/link_sender.sv ====
// link sender with input four-phase handshake, credit counter, credit retiming and valid-next launch

`timescale 1ns/100ps

module link_sender
  import wire_link_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              in_req,
  input  logic [data_w-1:0] in_data,
  input  logic              credit_return,
  output logic              in_ack,
  output logic              fwd_valid_next,
  output logic [data_w-1:0] fwd_data
);

  // ------------------------------
  // declarations
  // ------------------------------

  // credits currently held, one per free receiver slot
  logic [credit_w-1:0]      credit_cnt;
  // credit pulses travelling back across the wire
  logic [credit_stages-1:0] credit_pipe;
  // credit pulse after the full return distance
  logic                     credit_back;
  // word taken from the producer, waiting one cycle for launch
  logic [data_w-1:0]        word_q;
  // a new word is taken on this edge
  logic                     accept;

  // ------------------------------
  // input handshake
  // ------------------------------

  // a request is only taken when the previous handshake has closed
  // and the receiver is known to have room for it
  assign accept = in_req && !in_ack && (credit_cnt != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      in_ack <= 1'b0;
    end else if (accept) begin
      in_ack <= 1'b1;
    end else if (in_ack && !in_req) begin
      // producer has seen the ack and withdrawn, so close the handshake
      in_ack <= 1'b0;
    end
  end

  // ------------------------------
  // forward launch
  // ------------------------------

  // valid-next goes out on the acceptance edge itself
  always_ff @(posedge clk) begin
    if (reset) begin
      fwd_valid_next <= 1'b0;
    end else begin
      fwd_valid_next <= accept;
    end
  end

  // hold the word so in_data is free to change once in_req drops
  always_ff @(posedge clk) begin
    if (accept) begin
      word_q <= in_data;
    end
  end

  // data follows valid-next by one cycle, loaded only when a word launches
  always_ff @(posedge clk) begin
    if (fwd_valid_next) begin
      fwd_data <= word_q;
    end
  end

  // ------------------------------
  // credit return
  // ------------------------------

  // the return pulse is retimed over the same distance as the forward bus
  always_ff @(posedge clk) begin
    if (reset) begin
      credit_pipe <= '0;
    end else begin
      credit_pipe[0] <= credit_return;
      for (int i = 1; i < credit_stages; i++) begin
        credit_pipe[i] <= credit_pipe[i-1];
      end
    end
  end

  assign credit_back = credit_pipe[credit_stages-1];

  // spend on accept, add back on a returned pulse; both at once cancel out
  always_ff @(posedge clk) begin
    if (reset) begin
      credit_cnt <= credit_w'(buf_depth);
    end else if (accept && !credit_back) begin
      credit_cnt <= credit_cnt - 1'b1;
    end else if (!accept && credit_back) begin
      credit_cnt <= credit_cnt + 1'b1;
    end
  end

endmodule : link_sender

// ==== verilog/wire_link_pkg.sv ====
// link word width, forward and credit delay depths, receiver buffer and credit sizing

package wire_link_pkg;

  // ------------------------------
  // payload
  // ------------------------------

  // width of one word carried across the link
  localparam int data_w = 32;

  // ------------------------------
  // wire distance
  // ------------------------------

  // retiming stages on the wide forward bus
  localparam int fwd_stages = 3;

  // retiming stages on the single-bit credit return path
  // kept equal to the forward depth since both cross the same distance
  localparam int credit_stages = 3;

  // ------------------------------
  // flow control
  // ------------------------------

  // receiver buffer slots, which is also the sender's starting credit count
  localparam int buf_depth = 8;

  // index into the receiver buffer, log2 of buf_depth
  localparam int buf_idx_w = 3;

  // the credit counter must be able to hold the full value buf_depth,
  // so it is one bit wider than the buffer index
  localparam int credit_w = 4;

endpackage : wire_link_pkg

// ==== verilog/wire_link_top.sv ====
// wire link top level joining sender, forward delay line and receiver

`timescale 1ns/100ps

module wire_link_top
  import wire_link_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  // producer side
  input  logic              in_req,
  input  logic [data_w-1:0] in_data,
  output logic              in_ack,
  // consumer side
  input  logic              out_ack,
  output logic              out_req,
  output logic [data_w-1:0] out_data
);

  // ------------------------------
  // internal wires
  // ------------------------------

  // near end of the forward bus, straight from the sender
  logic              fwd_valid_next;
  logic [data_w-1:0] fwd_data;
  // far end of the forward bus, after the wire retiming
  logic              dly_valid_next;
  logic [data_w-1:0] dly_data;
  // one pulse per slot freed at the receiver
  logic              credit_return;

  // ------------------------------
  // blocks
  // ------------------------------

  link_sender i_sender (
    .clk            (clk),
    .reset          (reset),
    .in_req         (in_req),
    .in_data        (in_data),
    .credit_return  (credit_return),
    .in_ack         (in_ack),
    .fwd_valid_next (fwd_valid_next),
    .fwd_data       (fwd_data)
  );

  // the long wide wire, registered along its length
  delay_valid_next #(
    .Width     (data_w),
    .NumStages (fwd_stages)
  ) i_fwd_delay (
    .clk            (clk),
    .reset          (reset),
    .in_valid_next  (fwd_valid_next),
    .in             (fwd_data),
    .out_valid_next (dly_valid_next),
    .out            (dly_data)
  );

  link_receiver i_receiver (
    .clk            (clk),
    .reset          (reset),
    .dly_valid_next (dly_valid_next),
    .dly_data       (dly_data),
    .out_ack        (out_ack),
    .out_req        (out_req),
    .out_data       (out_data),
    .credit_return  (credit_return)
  );

endmodule : wire_link_top

// ==== wire_link_top.f ====
verilog/wire_link_pkg.sv
verilog/delay_valid_next.sv
verilog/link_sender.sv
verilog/link_receiver.sv
verilog/wire_link_top.sv
verification/wire_link_tb.sv
